// File: sources.f
logic/am_lock_pkg.sv
logic/am_pattern_compare.sv
logic/am_lock_fsm.sv
logic/am_lane_number.sv
logic/am_lock_lane.sv
test/tb_am_lock_lane.sv

// File: test/tb_am_lock_lane.sv
// testbench for the alignment marker lock of one lane
// blocks are built from the marker table, a small model predicts every output per cycle
module tb_am_lock_lane;

	localparam int CLK_PERIOD = 4;
	localparam int AM_PERIOD  = 64;
	localparam int LOCK_THR   = 3;
	localparam int UNLOCK_THR = 4;
	localparam int N_LANES    = 20;
	localparam int N_MARKERS  = 35;                            // markers over all tests
	localparam int N_BLOCKS   = (N_MARKERS + 8) * AM_PERIOD;   // cycles incl offsets and drops
	localparam int WATCHDOG   = N_BLOCKS * CLK_PERIOD * 2;

	logic        i_clock = 1'b0;
	logic        i_reset;
	logic        i_enable;
	logic        i_valid;
	logic        i_block_lock;
	logic [65:0] i_block;
	logic [4:0]  i_lock_thr;
	logic [2:0]  i_unlock_thr;
	logic [15:0] i_am_period;
	logic        o_am_lock;
	logic        o_start_of_lane;
	logic        o_resync;
	logic [4:0]  o_lane_number;
	logic        o_lane_valid;

	logic [31:0] lfsr = 32'h1a53_6236;
	int          n_checks = 0;
	int          n_errors = 0;

	// stimulus bookkeeping, all positions counted in valid blocks
	int          vcount = 0;       // valid blocks sent so far
	int          next_marker = 0;  // vcount of the next marker slot
	int          cur_lane = -1;    // lane sent in marker slots, -1 sends data
	int          corrupt_left = 0; // marker slots still to corrupt
	int          resync_seen = 0;
	int          sol_seen = 0;
	logic        last_lock;
	logic        last_lane_valid;
	logic [4:0]  last_lane_number;

	// reference model state
	am_lock_pkg::am_lock_state_e m_state = am_lock_pkg::INIT;
	logic        m_lock = 1'b0;
	logic        m_lane_valid = 1'b0;
	logic        m_ever_locked = 1'b0;
	int          m_lane = 0;
	int          m_last_lane = -1;
	int          m_good = 0;
	int          m_bad = 0;
	int          m_search = 0;  // search timer minus one
	int          m_sol_cnt = 0; // start of lane timer minus one

	am_lock_lane i_am_lock_lane
	(
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_enable        (i_enable),
		.i_valid         (i_valid),
		.i_block_lock    (i_block_lock),
		.i_block         (i_block),
		.i_lock_thr      (i_lock_thr),
		.i_unlock_thr    (i_unlock_thr),
		.i_am_period     (i_am_period),
		.o_am_lock       (o_am_lock),
		.o_start_of_lane (o_start_of_lane),
		.o_resync        (o_resync),
		.o_lane_number   (o_lane_number),
		.o_lane_valid    (o_lane_valid)
	);

	always #(CLK_PERIOD / 2) i_clock = ~i_clock;

	// taps 32 22 2 1, maximal length
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]}; // one step per bit
		end
		return v;
	endfunction

	function automatic logic [65:0] random_data();
		logic [65:0] v;
		v[65:64] = rand_bits(2);
		v[63:32] = rand_bits(32);
		v[31:0]  = rand_bits(32);
		v[8]     = v[40]; // M6 bit 0 equal to M2 bit 0, never a marker
		return v;
	endfunction

	// header, M0..M2, BIP3, inverted M0..M2, BIP7
	function automatic logic [65:0] make_marker(input int lane);
		logic [7:0] bip3;
		logic [7:0] bip7;
		bip3 = rand_bits(8); // bip bytes are don't care for the match
		bip7 = rand_bits(8);
		return {am_lock_pkg::SYNC_CTRL, am_lock_pkg::AM_TABLE[lane], bip3,
			~am_lock_pkg::AM_TABLE[lane], bip7};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// one clock cycle: drive, check against the model, then advance the model
	// mk_lane is the lane of an intact marker, -1 for anything else
	task automatic send_block(input logic valid, input logic blk_lock,
		input logic [65:0] blk, input int mk_lane);
		logic step;
		logic srch_done;
		logic sol_done;
		logic first;
		logic lock_entry;
		logic lock_next;
		logic exp_sol;
		logic exp_resync;
		#1;
		i_valid      = valid;
		i_block_lock = blk_lock;
		i_block      = blk;
		#2; // outputs settled, next edge still 1 unit away
		step       = valid && blk_lock;
		srch_done  = valid && (m_search + 1 == AM_PERIOD);
		sol_done   = valid && (m_sol_cnt + 1 == AM_PERIOD);
		first      = 1'b0;
		lock_entry = 1'b0;
		lock_next  = m_lock;
		exp_resync = 1'b0;
		if (!blk_lock)
		begin
			m_state   = am_lock_pkg::INIT; // block lock lost, start over
			lock_next = 1'b0;
		end
		else if (step)
		begin
			case (m_state)
				am_lock_pkg::INIT:
					m_state = am_lock_pkg::WAIT_1ST;
				am_lock_pkg::WAIT_1ST:
					if (mk_lane >= 0)
					begin
						first   = 1'b1;
						m_lane  = mk_lane;
						m_good  = 1;
						m_state = am_lock_pkg::WAIT_2ND;
					end
				am_lock_pkg::WAIT_2ND:
					if (srch_done && mk_lane == m_lane)
					begin
						m_good++;
						lock_entry = (m_good == LOCK_THR);
					end
					else if (srch_done)
						m_state = am_lock_pkg::WAIT_1ST; // expected marker missing
				default:
					if (srch_done && mk_lane == m_lane)
						m_bad = 0;
					else if (srch_done)
					begin
						m_bad++;
						if (m_bad == UNLOCK_THR)
						begin
							m_state   = am_lock_pkg::WAIT_1ST;
							lock_next = 1'b0;
						end
					end
			endcase
		end
		if (lock_entry)
		begin
			// first lock, marker off the old start of lane, or another lane
			exp_resync    = !m_ever_locked || !sol_done || (mk_lane != m_last_lane);
			m_state       = am_lock_pkg::LOCKED;
			lock_next     = 1'b1;
			m_bad         = 0;
			m_ever_locked = 1'b1;
		end
		exp_sol = valid && m_lock && sol_done;

		check_value("o_am_lock", o_am_lock, m_lock);
		check_value("o_lane_valid", o_lane_valid, m_lane_valid);
		if (m_lane_valid)
			check_value("o_lane_number", o_lane_number, m_last_lane);
		check_value("o_start_of_lane", o_start_of_lane, exp_sol);
		check_value("o_resync", o_resync, exp_resync);
		if (o_resync)
			resync_seen++;
		if (o_start_of_lane)
			sol_seen++;
		last_lock        = o_am_lock;
		last_lane_valid  = o_lane_valid;
		last_lane_number = o_lane_number;

		// what the coming edge does
		if (valid)
		begin
			m_search  = (first || srch_done) ? 0 : m_search + 1;
			m_sol_cnt = (lock_entry || sol_done) ? 0 : m_sol_cnt + 1;
			vcount++;
		end
		if (m_lock)
			m_last_lane = m_lane;
		m_lane_valid = m_lock;
		m_lock       = lock_next;
		@(posedge i_clock);
	endtask

	// runs until n marker slots went out, the last block sent is a marker slot
	task automatic run_markers(input int n_markers, input logic drops);
		int          sent;
		int          idx;
		logic        drop;
		logic [65:0] blk;
		sent = 0;
		while (sent < n_markers)
		begin
			drop = 1'b0;
			if (drops)
				drop = (rand_bits(2) == 0); // roughly one cycle in four idle
			if (drop)
				send_block(1'b0, 1'b1, random_data(), -1);
			else if (vcount == next_marker && cur_lane < 0)
			begin
				send_block(1'b1, 1'b1, random_data(), -1);
				next_marker += AM_PERIOD;
				sent++;
			end
			else if (vcount == next_marker && corrupt_left > 0)
			begin
				blk = make_marker(cur_lane);
				idx = rand_bits(6) % 50; // header and M fields only, bip flips are invisible
				if (idx < 24)
					idx = idx + 8;  // M4..M6
				else
					idx = idx + 16; // M0..M2 and the header
				blk[idx] = ~blk[idx];
				send_block(1'b1, 1'b1, blk, -1);
				corrupt_left--;
				next_marker += AM_PERIOD;
				sent++;
			end
			else if (vcount == next_marker)
			begin
				send_block(1'b1, 1'b1, make_marker(cur_lane), cur_lane);
				next_marker += AM_PERIOD;
				sent++;
			end
			else
				send_block(1'b1, 1'b1, random_data(), -1);
		end
	endtask

	task automatic run_data(input int n);
		int i;
		for (i = 0; i < n; i++)
			send_block(1'b1, 1'b1, random_data(), -1);
	endtask

	initial
	begin
		i_reset      = 1'b1;
		i_enable     = 1'b1;
		i_valid      = 1'b0;
		i_block_lock = 1'b1;
		i_block      = '0;
		i_lock_thr   = LOCK_THR;
		i_unlock_thr = UNLOCK_THR;
		i_am_period  = AM_PERIOD;
		repeat (3) @(posedge i_clock);
		#1 i_reset = 1'b0;
		@(posedge i_clock);

		// no markers at all, everything stays quiet
		next_marker = vcount + AM_PERIOD;
		run_markers(3, 1'b0);
		check_value("resync pulses without markers", resync_seen, 0);
		check_value("start of lane pulses without markers", sol_seen, 0);

		// markers of a random lane at a random position
		cur_lane    = rand_bits(5) % N_LANES;
		next_marker = vcount + 1 + (rand_bits(6) % AM_PERIOD);
		resync_seen = 0;
		run_markers(6, 1'b0);
		run_data(2);
		check_value("o_am_lock after 6 markers", last_lock, 1);
		check_value("o_lane_valid after lock", last_lane_valid, 1);
		check_value("o_lane_number after lock", last_lane_number, cur_lane);
		check_value("resync pulses at first lock", resync_seen, 1);

		// idle cycles while locked, start of lane only on marker blocks
		sol_seen = 0;
		run_markers(5, 1'b1);
		run_data(2);
		check_value("start of lane pulses with idle cycles", sol_seen, 5);

		// 3 bad markers are tolerated
		corrupt_left = 3;
		run_markers(5, 1'b0);
		run_data(2);
		check_value("o_am_lock after 3 bad markers", last_lock, 1);

		// the 4th bad marker in a row unlocks
		corrupt_left = 4;
		run_markers(4, 1'b0);
		run_data(2);
		check_value("o_am_lock after 4 bad markers", last_lock, 0);
		check_value("o_lane_valid after 4 bad markers", last_lane_valid, 0);

		// relock in place, deskew stays valid
		resync_seen = 0;
		run_markers(3, 1'b0);
		run_data(2);
		check_value("o_am_lock after relock", last_lock, 1);
		check_value("resync pulses on relock", resync_seen, 0);

		// block lock glitch, markers keep their position
		send_block(1'b1, 1'b0, random_data(), -1);
		resync_seen = 0;
		run_markers(3, 1'b0);
		run_data(2);
		check_value("o_am_lock after glitch", last_lock, 1);
		check_value("resync pulses after glitch", resync_seen, 0);

		// block lock glitch, markers come back shifted
		send_block(1'b1, 1'b0, random_data(), -1);
		next_marker += 1 + (rand_bits(6) % (AM_PERIOD - 1));
		resync_seen = 0;
		run_markers(3, 1'b0);
		run_data(2);
		check_value("o_am_lock after shift", last_lock, 1);
		check_value("resync pulses after shift", resync_seen, 1);

		// block lock glitch, another lane at the same position
		send_block(1'b1, 1'b0, random_data(), -1);
		cur_lane    = (cur_lane + 1 + (rand_bits(5) % (N_LANES - 1))) % N_LANES;
		resync_seen = 0;
		run_markers(3, 1'b0);
		run_data(2);
		check_value("o_am_lock after lane swap", last_lock, 1);
		check_value("resync pulses after lane swap", resync_seen, 1);
		check_value("o_lane_number after lane swap", last_lane_number, cur_lane);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// stops a run that hangs
	initial
	begin
		#(WATCHDOG);
		$display("watchdog expired, the tests did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: logic/am_lock_lane.sv
// alignment marker lock for one physical lane of a 40G/100G pcs
module am_lock_lane
#(
	parameter int N_ALIGNERS     = 20, // pcs lanes searched, first table entries
	parameter int NB_VALID_CNT   = 5,
	parameter int NB_INVALID_CNT = 3,
	parameter int NB_AM_PERIOD   = 16,
	parameter int NB_LANE_ID     = 5
)
(
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  logic                      i_enable,
	input  logic                      i_valid,
	input  logic                      i_block_lock,
	input  logic [65:0]               i_block,
	input  logic [NB_VALID_CNT-1:0]   i_lock_thr,
	input  logic [NB_INVALID_CNT-1:0] i_unlock_thr,
	input  logic [NB_AM_PERIOD-1:0]   i_am_period,
	output logic                      o_am_lock,
	output logic                      o_start_of_lane,
	output logic                      o_resync,
	output logic [NB_LANE_ID-1:0]     o_lane_number,
	output logic                      o_lane_valid
);

	logic [N_ALIGNERS-1:0] match_vector;
	logic [N_ALIGNERS-1:0] match_mask;
	logic                  am_valid;
	logic                  am_lock;
	logic                  relock;
	logic                  lane_changed;

	am_pattern_compare
	#(
		.N_ALIGNERS     (N_ALIGNERS)
	)
	u_compare
	(
		.i_block        (i_block),
		.i_match_mask   (match_mask),
		.o_match_vector (match_vector),
		.o_am_valid     (am_valid)
	);

	am_lock_fsm
	#(
		.N_ALIGNERS      (N_ALIGNERS),
		.NB_VALID_CNT    (NB_VALID_CNT),
		.NB_INVALID_CNT  (NB_INVALID_CNT),
		.NB_AM_PERIOD    (NB_AM_PERIOD)
	)
	u_fsm
	(
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_enable        (i_enable),
		.i_valid         (i_valid),
		.i_block_lock    (i_block_lock),
		.i_am_valid      (am_valid),
		.i_match_vector  (match_vector),
		.i_lock_thr      (i_lock_thr),
		.i_unlock_thr    (i_unlock_thr),
		.i_am_period     (i_am_period),
		.i_lane_changed  (lane_changed), // closes the lane swap case of resync
		.o_match_mask    (match_mask),
		.o_am_lock       (am_lock),
		.o_relock        (relock),
		.o_start_of_lane (o_start_of_lane),
		.o_resync        (o_resync)
	);

	am_lane_number
	#(
		.N_ALIGNERS     (N_ALIGNERS),
		.NB_LANE_ID     (NB_LANE_ID)
	)
	u_lane_number
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_match_mask   (match_mask),
		.i_am_lock      (am_lock),
		.i_relock       (relock),
		.o_lane_number  (o_lane_number),
		.o_lane_valid   (o_lane_valid),
		.o_lane_changed (lane_changed)
	);

	assign o_am_lock = am_lock;

endmodule

// File: logic/am_lane_number.sv
// reports the pcs lane found by the lock fsm as a binary number
// the last lane is kept across unlock to spot a lane swap on relock
module am_lane_number
#(
	parameter int N_ALIGNERS = 20,
	parameter int NB_LANE_ID = 5
)
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic [N_ALIGNERS-1:0] i_match_mask, // one hot once the fsm narrowed it
	input  logic                  i_am_lock,
	input  logic                  i_relock,     // lock entry strobe from the fsm
	output logic [NB_LANE_ID-1:0] o_lane_number,
	output logic                  o_lane_valid,
	output logic                  o_lane_changed
);

	logic [NB_LANE_ID-1:0]       lane_idx;  // encoded mask
	logic [NB_LANE_ID-1:0]       lane_q;    // lane of the current or last lock
	am_lock_pkg::am_lock_state_e lane_hist; // INIT never locked, LOCKED held, WAIT_1ST lost

	if ((1 << NB_LANE_ID) < N_ALIGNERS)
	begin : g_width_check
		$error("am_lane_number: NB_LANE_ID too narrow for N_ALIGNERS");
	end

	// one hot to binary, the mask is only read after narrowing
	always_comb
	begin
		lane_idx = '0;
		for (int k = 0; k < N_ALIGNERS; k++)
		begin
			if (i_match_mask[k])
				lane_idx = NB_LANE_ID'(k);
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_am_lock)
			lane_q <= lane_idx; // held untouched while unlocked
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			lane_hist <= am_lock_pkg::INIT;
		else if (i_am_lock)
			lane_hist <= am_lock_pkg::LOCKED;
		else if (lane_hist == am_lock_pkg::LOCKED)
			lane_hist <= am_lock_pkg::WAIT_1ST; // searching again, lane_q still valid
	end

	assign o_lane_number  = lane_q;
	assign o_lane_valid   = (lane_hist == am_lock_pkg::LOCKED);
	// only meaningful once a previous lock left a lane behind
	assign o_lane_changed = i_relock && (lane_hist != am_lock_pkg::INIT)
		&& (lane_idx != lane_q);

endmodule

// File: logic/am_lock_fsm.sv
// alignment marker lock fsm for one lane
// search timer follows the marker found in WAIT_1ST
// lock timer free runs and is re-aligned on each lock, it drives start of lane
// a lock where both timers disagree means the marker moved inside the stream
module am_lock_fsm
#(
	parameter int N_ALIGNERS     = 20,
	parameter int NB_VALID_CNT   = 5,
	parameter int NB_INVALID_CNT = 3,
	parameter int NB_AM_PERIOD   = 16
)
(
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  logic                      i_enable,
	input  logic                      i_valid,
	input  logic                      i_block_lock,   // low holds the fsm in INIT
	input  logic                      i_am_valid,
	input  logic [N_ALIGNERS-1:0]     i_match_vector,
	input  logic [NB_VALID_CNT-1:0]   i_lock_thr,     // markers needed for lock, first included
	input  logic [NB_INVALID_CNT-1:0] i_unlock_thr,   // consecutive bad markers for unlock
	input  logic [NB_AM_PERIOD-1:0]   i_am_period,    // marker spacing in valid blocks
	input  logic                      i_lane_changed, // relock found another pcs lane
	output logic [N_ALIGNERS-1:0]     o_match_mask,
	output logic                      o_am_lock,
	output logic                      o_relock,
	output logic                      o_start_of_lane,
	output logic                      o_resync
);

	am_lock_pkg::am_lock_state_e state;
	am_lock_pkg::am_lock_state_e state_next;

	logic [N_ALIGNERS-1:0]     match_mask;
	logic [N_ALIGNERS-1:0]     match_mask_next;
	logic                      am_lock;
	logic                      am_lock_next;

	logic [NB_AM_PERIOD-1:0]   timer_search;
	logic [NB_AM_PERIOD-1:0]   timer_lock;
	logic                      search_done;
	logic                      lock_timer_done;

	logic [NB_VALID_CNT-1:0]   good_cnt;
	logic [NB_VALID_CNT-1:0]   good_cnt_inc;
	logic [NB_INVALID_CNT-1:0] bad_cnt;
	logic [NB_INVALID_CNT-1:0] bad_cnt_inc;

	logic                      step;       // fsm may act on this block
	logic                      first_am;   // first marker taken in WAIT_1ST
	logic                      good_am;    // confirming marker, lock not yet reached
	logic                      lock_hit;   // marker that completes the lock count
	logic                      clear_bad;  // good marker while locked
	logic                      bad_am;     // missing marker while locked
	logic                      lock_entry;
	logic                      first_lock_done;
	logic                      skew_moved;

	// block lock low also blocks the strobes, the state register goes to INIT anyway
	assign step = i_enable && i_valid && i_block_lock;

	assign search_done     = (timer_search == i_am_period);
	assign lock_timer_done = (timer_lock == i_am_period);
	assign good_cnt_inc    = good_cnt + 1'b1;
	assign bad_cnt_inc     = bad_cnt + 1'b1;

	always_comb
	begin
		state_next      = state;
		match_mask_next = match_mask;
		am_lock_next    = am_lock;
		first_am        = 1'b0;
		good_am         = 1'b0;
		lock_hit        = 1'b0;
		clear_bad       = 1'b0;
		bad_am          = 1'b0;
		case (state)
			am_lock_pkg::INIT:
			begin
				match_mask_next = {N_ALIGNERS{1'b1}}; // search every lane
				am_lock_next    = 1'b0;
				state_next      = am_lock_pkg::WAIT_1ST;
			end
			am_lock_pkg::WAIT_1ST:
			begin
				if (i_am_valid)
				begin
					first_am        = 1'b1;
					match_mask_next = i_match_vector; // narrow to the lane found
					state_next      = am_lock_pkg::WAIT_2ND;
				end
			end
			am_lock_pkg::WAIT_2ND:
			begin
				if (search_done && i_am_valid)
				begin
					if (good_cnt_inc == i_lock_thr)
					begin
						lock_hit     = 1'b1;
						am_lock_next = 1'b1;
						state_next   = am_lock_pkg::LOCKED;
					end
					else
						good_am = 1'b1;
				end
				else if (search_done) // marker missing where expected
				begin
					match_mask_next = {N_ALIGNERS{1'b1}};
					state_next      = am_lock_pkg::WAIT_1ST;
				end
			end
			am_lock_pkg::LOCKED:
			begin
				if (search_done && i_am_valid)
					clear_bad = 1'b1;
				else if (search_done && (bad_cnt_inc == i_unlock_thr))
				begin
					// too many bad markers in a row, restart the search
					match_mask_next = {N_ALIGNERS{1'b1}};
					am_lock_next    = 1'b0;
					state_next      = am_lock_pkg::WAIT_1ST;
				end
				else if (search_done)
					bad_am = 1'b1;
			end
			default:
				state_next = am_lock_pkg::INIT;
		endcase
	end

	// state, lock flag and search mask move together
	always_ff @(posedge i_clock)
	begin
		if (i_reset || !i_block_lock)
		begin
			state      <= am_lock_pkg::INIT;
			am_lock    <= 1'b0;
			match_mask <= {N_ALIGNERS{1'b1}};
		end
		else if (step)
		begin
			state      <= state_next;
			am_lock    <= am_lock_next;
			match_mask <= match_mask_next;
		end
	end

	// consecutive good markers of the current search, the first one counts
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			good_cnt <= '0;
		else if (step && first_am)
			good_cnt <= NB_VALID_CNT'(1);
		else if (step && good_am)
			good_cnt <= good_cnt_inc;
	end

	// consecutive bad markers while locked
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			bad_cnt <= '0;
		else if (step && (lock_hit || clear_bad))
			bad_cnt <= '0;
		else if (step && bad_am)
			bad_cnt <= bad_cnt_inc;
	end

	// search timer, reloaded on the first marker so done falls on marker positions
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			timer_search <= NB_AM_PERIOD'(1);
		else if (i_valid)
		begin
			if ((step && first_am) || search_done)
				timer_search <= NB_AM_PERIOD'(1);
			else
				timer_search <= timer_search + 1'b1;
		end
	end

	// lock timer keeps running through unlock so a relock can be compared with it
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			timer_lock <= NB_AM_PERIOD'(1);
		else if (i_valid)
		begin
			if (lock_entry || lock_timer_done)
				timer_lock <= NB_AM_PERIOD'(1);
			else
				timer_lock <= timer_lock + 1'b1;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			first_lock_done <= 1'b0;
		else if (lock_entry)
			first_lock_done <= 1'b1;
	end

	assign lock_entry = step && lock_hit;
	assign skew_moved = (timer_lock != timer_search); // search_done holds here

	assign o_match_mask    = match_mask;
	assign o_am_lock       = am_lock;
	assign o_relock        = lock_entry;
	assign o_start_of_lane = i_valid && am_lock && lock_timer_done;
	// deskew must restart on first lock, moved marker or different lane
	assign o_resync        = lock_entry && (!first_lock_done || skew_moved || i_lane_changed);

endmodule

// File: logic/am_pattern_compare.sv
// compares one 66b block against the markers of all searched lanes
// block layout is big endian:
//   [65:64] sync header
//   [63:40] M0 M1 M2
//   [39:32] BIP3
//   [31:8]  M4 M5 M6
//   [7:0]   BIP7
module am_pattern_compare
#(
	parameter int N_ALIGNERS = 20
)
(
	input  logic [65:0]            i_block,
	input  logic [N_ALIGNERS-1:0]  i_match_mask,   // lanes still allowed by the fsm
	output logic [N_ALIGNERS-1:0]  o_match_vector, // one bit per matching lane
	output logic                   o_am_valid      // any enabled marker seen
);

	logic [1:0]            header;
	logic [23:0]           am_field;     // M0..M2
	logic [23:0]           am_inv_field; // M4..M6
	logic                  header_ok;
	logic                  inv_ok;
	logic                  frame_ok;
	logic [N_ALIGNERS-1:0] lane_hit;     // raw table compare, not masked yet

	// the table only holds N_LANES_MAX entries
	if (N_ALIGNERS > am_lock_pkg::N_LANES_MAX)
	begin : g_size_check
		$error("am_pattern_compare: N_ALIGNERS exceeds the marker table");
	end

	assign header       = i_block[65:64];
	assign am_field     = i_block[63:40];
	assign am_inv_field = i_block[31:8];

	// shared checks, done once for all lanes
	assign header_ok = (header == am_lock_pkg::SYNC_CTRL);
	assign inv_ok    = (am_field == ~am_inv_field); // M4..M6 must mirror M0..M2
	assign frame_ok  = header_ok && inv_ok;

	// one 24 bit compare per searched lane, all in parallel
	for (genvar k = 0; k < N_ALIGNERS; k++)
	begin : g_lane
		assign lane_hit[k] = (am_field == am_lock_pkg::AM_TABLE[k]);
	end

	// a hit only counts if the framing holds and the fsm still searches that lane
	assign o_match_vector = lane_hit & i_match_mask & {N_ALIGNERS{frame_ok}};
	assign o_am_valid     = |o_match_vector;

endmodule

// File: logic/am_lock_pkg.sv
package am_lock_pkg;

	// number of pcs lanes with a defined alignment marker
	localparam int N_LANES_MAX = 20;

	// sync header of a control block, markers always carry it
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	// marker bytes {M0, M1, M2} per pcs lane
	// M4..M6 on the wire are the bitwise inverse of these
	// BIP3 and BIP7 are not part of the pattern
	localparam logic [23:0] AM_TABLE [N_LANES_MAX] = '{
		24'hc1_68_21, // lane 0
		24'h9d_71_8e, // lane 1
		24'h59_4b_e8, // lane 2
		24'h4d_95_7b, // lane 3
		24'hf5_07_09, // lane 4
		24'hdd_14_c2, // lane 5
		24'h9a_4a_26, // lane 6
		24'h7b_45_66, // lane 7
		24'ha0_24_76, // lane 8
		24'h68_c9_fb, // lane 9
		24'hfd_6c_99, // lane 10
		24'hb9_91_55, // lane 11
		24'h5c_b9_b2, // lane 12
		24'h1a_f8_bd, // lane 13
		24'h83_c7_ca, // lane 14
		24'h35_36_cd, // lane 15
		24'hc4_31_4c, // lane 16
		24'had_d6_b7, // lane 17
		24'h5f_66_2a, // lane 18
		24'hc0_f0_e5  // lane 19
	};

	// alignment marker lock states, as in the lock diagram of clause 82
	// INIT      search mask opened, lock dropped
	// WAIT_1ST  looking for any enabled marker
	// WAIT_2ND  confirming markers one period apart
	// LOCKED    counting bad markers until unlock
	typedef enum logic [1:0] {
		INIT     = 2'd0,
		WAIT_1ST = 2'd1,
		WAIT_2ND = 2'd2,
		LOCKED   = 2'd3
	} am_lock_state_e;

endpackage
